/* instr_capture.sv */
// ##############################
// Input side: latches a strobed pin word for the core
// One holding entry, extra strobes while full set a sticky overrun
// ##############################

`include "team_01_defines.svh"

module instr_capture import team_01_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  en_i,
   input  word_t pin_word_i,
   input  logic  pin_strobe_i,
   input  logic  instr_take_i,
   output word_t instr_o,
   output logic  instr_pending_o,
   output logic  overrun_o
);

   // Strobe only counts while enabled
   logic strobe_en;

   assign strobe_en = en_i & pin_strobe_i;

   // Pending and overrun flags
   always_ff @(posedge clk) begin
      if (rst_i) begin
         instr_pending_o <= 1'b0;
         overrun_o       <= 1'b0;
      end else begin
         // Core consumed the word
         if (instr_take_i) begin
            instr_pending_o <= 1'b0;
         end
         if (strobe_en) begin
            // Entry still full, word is dropped
            if (instr_pending_o) begin
               overrun_o <= 1'b1;
            end else begin
               instr_pending_o <= 1'b1;
            end
         end
      end
   end

   // Holding register, loaded only into a free entry
   always_ff @(posedge clk) begin
      if (strobe_en && !instr_pending_o) begin
         instr_o <= pin_word_i;
      end
   end

   // Core must not take a word that was never captured
   a_take_needs_pending: assert property (
      @(posedge clk) disable iff (rst_i)
      instr_take_i |-> instr_pending_o
   );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the team_01 testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f team_01.f \
      --top-module team_01_tb -Mdir obj_dir -o team_01_sim; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/team_01_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_wb_memory.sv */
// ##############################
// Testbench Wishbone slave, 64 words, byte-lane writes
// ACK after 0..3 LFSR-chosen waits, or a fixed wait count
// ##############################

module tb_wb_memory import team_01_pkg::*; (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       rand_i,
   input  logic [3:0] wait_i,
   input  addr_t      adr_i,
   input  word_t      dat_i,
   input  sel_t       sel_i,
   input  logic       we_i,
   input  logic       stb_i,
   input  logic       cyc_i,
   output word_t      dat_o,
   output logic       ack_o
);

   // Open to the testbench for direct reads
   word_t      mem [64];
   word_t      dat_q     = '0;
   logic       ack_q     = 1'b0;
   logic       active    = 1'b0;
   logic [3:0] wait_left = '0;
   logic [7:0] lfsr_q    = 8'd90;
   logic [1:0] draw;
   logic [5:0] idx;

   assign dat_o = dat_q;
   assign ack_o = ack_q;
   assign idx   = adr_i[7:2];

   // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   // Fill pattern built from the whole word index
   initial begin
      for (int k = 0; k < 64; k++) begin
         mem[k[5:0]] = 32'h5A00_0000 ^ (k * 32'h0001_0307);
      end
   end

   always @(posedge clk) begin
      ack_q <= 1'b0;
      if (rst_i) begin
         active = 1'b0;
      end else if (cyc_i && stb_i && !ack_q) begin
         // New cycle, pick its wait count
         if (!active) begin
            active  = 1'b1;
            lfsr_q  = lfsr_step(lfsr_q);
            draw[0] = lfsr_q[0];
            lfsr_q  = lfsr_step(lfsr_q);
            draw[1] = lfsr_q[0];
            wait_left = rand_i ? {2'b00, draw} : wait_i;
         end
         if (wait_left == 4'd0) begin
            active = 1'b0;
            ack_q <= 1'b1;
            if (we_i) begin
               if (sel_i[0]) mem[idx][7:0]   = dat_i[7:0];
               if (sel_i[1]) mem[idx][15:8]  = dat_i[15:8];
               if (sel_i[2]) mem[idx][23:16] = dat_i[23:16];
               if (sel_i[3]) mem[idx][31:24] = dat_i[31:24];
            end else begin
               dat_q <= mem[idx];
            end
         end else begin
            wait_left = wait_left - 4'd1;
         end
      end
   end

endmodule

/* team_01.f */
+incdir+.
team_01_pkg.sv
instr_capture.sv
team_01_cpu.sv
wishbone_manager.sv
team_01.sv
tb_wb_memory.sv
team_01_tb.sv

/* team_01.sv */
// ##############################
// Top of the team_01 slice: pins -> capture -> core -> Wishbone
// Overrun and busy shown on gpio_out, everything else tied low
// ##############################

`include "team_01_defines.svh"

module team_01 import team_01_pkg::*; (
   input  logic         clk,
   input  logic         rst_i,
   // Chip enable, gates new work
   input  logic         en_i,
   // Logic analyser, not used here
   input  logic [127:0] la_data_in_i,
   output logic [127:0] la_data_out_o,
   input  logic [127:0] la_oenb_i,
   // Breakout pins, oeb is active low
   input  logic [33:0]  gpio_in_i,
   output logic [33:0]  gpio_out_o,
   output logic [33:0]  gpio_oeb_o,
   // Wishbone
   input  word_t        dat_i,
   input  logic         ack_i,
   output addr_t        adr_o,
   output word_t        dat_o,
   output sel_t         sel_o,
   output logic         we_o,
   output logic         stb_o,
   output logic         cyc_o
);

   // Capture to core
   word_t instr;
   logic  instr_pending;
   logic  instr_take;
   logic  overrun;

   // Core to manager
   word_t cpu_dat_i;
   word_t cpu_dat_o;
   addr_t adr_i;
   sel_t  sel_i;
   logic  write_i;
   logic  read_i;
   logic  busy_o;

   // Word on the low pins, strobe just above
   instr_capture i_capture (
      .clk             (clk),
      .rst_i           (rst_i),
      .en_i            (en_i),
      .pin_word_i      (gpio_in_i[`TEAM_DATA_W-1:0]),
      .pin_strobe_i    (gpio_in_i[`TEAM_DATA_W]),
      .instr_take_i    (instr_take),
      .instr_o         (instr),
      .instr_pending_o (instr_pending),
      .overrun_o       (overrun)
   );

   team_01_cpu i_cpu (
      .clk             (clk),
      .rst_i           (rst_i),
      .en_i            (en_i),
      .instr_i         (instr),
      .instr_pending_i (instr_pending),
      .instr_take_o    (instr_take),
      .busy_i          (busy_o),
      .cpu_dat_i       (cpu_dat_o),
      .cpu_dat_o       (cpu_dat_i),
      .adr_o           (adr_i),
      .sel_o           (sel_i),
      .write_o         (write_i),
      .read_o          (read_i)
   );

   wishbone_manager i_wbm (
      .clk       (clk),
      .rst_i     (rst_i),
      .dat_i     (dat_i),
      .ack_i     (ack_i),
      .cpu_dat_i (cpu_dat_i),
      .adr_i     (adr_i),
      .sel_i     (sel_i),
      .write_i   (write_i),
      .read_i    (read_i),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .sel_o     (sel_o),
      .we_o      (we_o),
      .stb_o     (stb_o),
      .cyc_o     (cyc_o),
      .cpu_dat_o (cpu_dat_o),
      .busy_o    (busy_o)
   );

   assign la_data_out_o = '0;

   // Status pins, low bits unused
   assign gpio_out_o[`TEAM_DATA_W-1:0]  = '0;
   assign gpio_out_o[`TEAM_OVR_PIN]     = overrun;
   assign gpio_out_o[`TEAM_OVR_PIN + 1] = busy_o;

   // Only the two status pins drive
   assign gpio_oeb_o = ~(34'b11 << `TEAM_OVR_PIN);

endmodule

/* team_01_cpu.sv */
// ##############################
// Register-machine core: decode, register file, ALU, bus requests
// Takes one captured word at a time, waits on busy for loads/stores
// ##############################

`include "team_01_defines.svh"

module team_01_cpu import team_01_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  en_i,
   input  word_t instr_i,
   input  logic  instr_pending_i,
   output logic  instr_take_o,
   input  logic  busy_i,
   input  word_t cpu_dat_i,
   output word_t cpu_dat_o,
   output addr_t adr_o,
   output sel_t  sel_o,
   output logic  write_o,
   output logic  read_o
);

   // Register file, r0 never written
   word_t regs [`TEAM_NREGS];

   cpu_state_e state_q;
   reg_idx_t   rd_q;
   logic       load_q;

   // Decoded fields
   opcode_e  opcode;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    imm;
   word_t    rs1_val;
   word_t    rs2_val;
   word_t    alu_res;
   addr_t    eff_addr;
   logic     is_alu;

   // Register file write port
   logic     rf_we;
   reg_idx_t rf_waddr;
   word_t    rf_wdata;

   assign opcode = opcode_e'(instr_i[31 -: `TEAM_OP_W]);
   assign rd     = instr_i[27:25];
   assign rs1    = instr_i[24:22];
   assign rs2    = instr_i[21:19];
   // Sign-extended 16-bit immediate
   assign imm    = {{(`TEAM_DATA_W - 16){instr_i[15]}}, instr_i[15:0]};

   // r0 reads as zero
   assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

   // Wraps modulo 2^32
   assign eff_addr = rs1_val + imm;

   // Consume a word only when idle, enabled and the bus is free
   assign instr_take_o = (state_q == READY) && instr_pending_i && en_i && !busy_i;

   // ALU
   always_comb begin
      alu_res = '0;
      is_alu  = 1'b1;
      case (opcode)
         OP_ADDI: alu_res = rs1_val + imm;
         OP_ADD:  alu_res = rs1_val + rs2_val;
         OP_SUB:  alu_res = rs1_val - rs2_val;
         OP_AND:  alu_res = rs1_val & rs2_val;
         OP_OR:   alu_res = rs1_val | rs2_val;
         OP_XOR:  alu_res = rs1_val ^ rs2_val;
         default: is_alu  = 1'b0;
      endcase
   end

   // Bus request, valid in the take cycle only
   assign adr_o   = eff_addr;
   assign read_o  = instr_take_o && (opcode == OP_LW);
   assign write_o = instr_take_o && ((opcode == OP_SW) || (opcode == OP_SB));

   // SB drives one lane from address bits 1:0, byte copied to all lanes
   always_comb begin
      if (opcode == OP_SB) begin
         sel_o     = sel_t'(4'b0001 << eff_addr[1:0]);
         cpu_dat_o = {4{rs2_val[7:0]}};
      end else begin
         sel_o     = 4'b1111;
         cpu_dat_o = rs2_val;
      end
   end

   // Write-back source: ALU at take, load data when busy drops
   always_comb begin
      rf_we    = 1'b0;
      rf_waddr = rd;
      rf_wdata = alu_res;
      if (instr_take_o && is_alu) begin
         rf_we = 1'b1;
      end else if ((state_q == WAIT_BUS) && !busy_i && load_q) begin
         rf_we    = 1'b1;
         rf_waddr = rd_q;
         rf_wdata = cpu_dat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rf_we && (rf_waddr != '0)) begin
         regs[rf_waddr] <= rf_wdata;
      end
   end

   // Sequencer
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= READY;
         load_q  <= 1'b0;
      end else begin
         case (state_q)
            READY: begin
               if (read_o || write_o) begin
                  state_q <= WAIT_BUS;
                  load_q  <= read_o;
               end
            end
            WAIT_BUS: begin
               // Finishes even with en low
               if (!busy_i) begin
                  state_q <= READY;
                  load_q  <= 1'b0;
               end
            end
            default: state_q <= READY;
         endcase
      end
   end

   // Destination of an outstanding load
   always_ff @(posedge clk) begin
      if (read_o) begin
         rd_q <= rd;
      end
   end

   // Manager must answer a request with busy on the next edge
   a_request_answered: assert property (
      @(posedge clk) disable iff (rst_i)
      (read_o || write_o) |=> busy_i
   );

endmodule

/* team_01_defines.svh */
// ##############################
// Shared width and pin constants for the team_01 user-area slice
// Include in any RTL file that sizes data, registers or pins
// ##############################

`ifndef TEAM_01_DEFINES_SVH
`define TEAM_01_DEFINES_SVH

// Bus and register width in bits
`define TEAM_DATA_W 32

// Register file depth, r0 reads as zero
`define TEAM_NREGS 8

// Opcode field width, top bits of the instruction
`define TEAM_OP_W 4

// gpio_out bit carrying the sticky overrun flag
// Busy sits on the bit just above it
`define TEAM_OVR_PIN 32

`endif

/* team_01_pkg.sv */
// ##############################
// Types shared by capture, core and Wishbone manager
// Pull in with a wildcard import in the module header
// ##############################

package team_01_pkg;

   // Data word on bus and in registers
   typedef logic [31:0] word_t;

   // Byte address on the bus
   typedef logic [31:0] addr_t;

   // One bit per byte lane
   typedef logic [3:0] sel_t;

   // Index into the eight-entry register file
   typedef logic [2:0] reg_idx_t;

   // Instruction opcodes, unlisted codes act as no-ops
   typedef enum logic [3:0] {
      OP_ADDI = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_LW   = 4'd6,
      OP_SW   = 4'd7,
      OP_SB   = 4'd8
   } opcode_e;

   // Bus manager FSM
   typedef enum logic {IDLE, WAIT_ACK} wbm_state_e;

   // Core FSM
   typedef enum logic {READY, WAIT_BUS} cpu_state_e;

endpackage

/* team_01_tb.sv */
// ##############################
// Directed tests for team_01: pins in, Wishbone memory out
// Reference register and memory models follow the ISA rules
// ##############################

module team_01_tb import team_01_pkg::*; ();

   // About 70 instructions at up to 12 cycles, plus resets and idle waits
   localparam int WORST_CYCLES = 1000;
   localparam int LIMIT        = 20 * WORST_CYCLES;

   logic         clk;
   logic         rst_i;
   logic         en_i;
   logic [127:0] la_data_in;
   logic [127:0] la_data_out;
   logic [127:0] la_oenb;
   logic [33:0]  gpio_in;
   logic [33:0]  gpio_out;
   logic [33:0]  gpio_oeb;
   word_t        dat_r;
   word_t        dat_w;
   addr_t        adr;
   sel_t         sel;
   logic         ack;
   logic         we;
   logic         stb;
   logic         cyc;
   logic         rand_dly;
   logic [3:0]   fixed_wait;

   // Reference models
   word_t regs_m [8];
   word_t mem_m [64];

   string cur_test    = "init";
   int    checks      = 0;
   int    errors      = 0;
   int    test_errors = 0;
   int    tests_run   = 0;
   int    cycles      = 0;
   int    bus_cycles  = 0;

   // Bus monitor state
   logic  was_open = 1'b0;
   logic  ack_prev = 1'b0;
   logic  cyc_prev = 1'b0;
   addr_t open_adr = '0;
   sel_t  open_sel = '0;
   sel_t  last_sel = '0;

   team_01 i_dut (
      .clk           (clk),
      .rst_i         (rst_i),
      .en_i          (en_i),
      .la_data_in_i  (la_data_in),
      .la_data_out_o (la_data_out),
      .la_oenb_i     (la_oenb),
      .gpio_in_i     (gpio_in),
      .gpio_out_o    (gpio_out),
      .gpio_oeb_o    (gpio_oeb),
      .dat_i         (dat_r),
      .ack_i         (ack),
      .adr_o         (adr),
      .dat_o         (dat_w),
      .sel_o         (sel),
      .we_o          (we),
      .stb_o         (stb),
      .cyc_o         (cyc)
   );

   tb_wb_memory i_mem (
      .clk    (clk),
      .rst_i  (rst_i),
      .rand_i (rand_dly),
      .wait_i (fixed_wait),
      .adr_i  (adr),
      .dat_i  (dat_w),
      .sel_i  (sel),
      .we_i   (we),
      .stb_i  (stb),
      .cyc_i  (cyc),
      .dat_o  (dat_r),
      .ack_o  (ack)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout: the run did not end within %0d clock cycles", LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic check_val(input string name, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   // Wishbone rule: held until ACK, dropped one edge later
   always begin
      @(posedge clk);
      #1;
      if (was_open) begin
         check_val({cur_test, " cyc/stb held"}, 32'd1, 32'(cyc && stb));
         check_val({cur_test, " adr held"}, open_adr, adr);
         check_val({cur_test, " sel held"}, 32'(open_sel), 32'(sel));
      end
      if (ack_prev) check_val({cur_test, " cyc dropped"}, 32'd0, 32'(cyc));
      if (cyc && !cyc_prev) bus_cycles++;
      if (cyc && stb) begin
         open_adr = adr;
         open_sel = sel;
         last_sel = sel;
      end
      was_open = cyc && stb && !ack;
      ack_prev = ack;
      cyc_prev = cyc;
   end

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic apply_reset();
      rst_i = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      rst_i = 1'b0;
   endtask

   function automatic word_t enc(input logic [3:0] op, input reg_idx_t rd,
                                 input reg_idx_t rs1, input reg_idx_t rs2,
                                 input logic [15:0] imm);
      return {op, rd, rs1, rs2, 3'b000, imm};
   endfunction

   // ISA rules applied to the reference models
   task automatic model_exec(input word_t w);
      logic [3:0] op;
      reg_idx_t   rd;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      ea;
      word_t      res;
      logic [5:0] idx;
      op  = w[31:28];
      rd  = w[27:25];
      a   = regs_m[w[24:22]];
      b   = regs_m[w[21:19]];
      imm = {{16{w[15]}}, w[15:0]};
      ea  = a + imm;
      idx = ea[7:2];
      res = '0;
      case (op)
         4'd0: res = a + imm;
         4'd1: res = a + b;
         4'd2: res = a - b;
         4'd3: res = a & b;
         4'd4: res = a | b;
         4'd5: res = a ^ b;
         4'd6: res = mem_m[idx];
         4'd7: mem_m[idx] = b;
         // Only the addressed byte lane changes
         4'd8: mem_m[idx] = (mem_m[idx] & ~(32'hFF << (8 * ea[1:0]))) |
                            ({24'h0, b[7:0]} << (8 * ea[1:0]));
         default: ;
      endcase
      if (op <= 4'd6 && rd != 3'd0) regs_m[rd] = res;
   endtask

   task automatic strobe_word(input word_t w);
      gpio_in = {2'b01, w};
      step();
      gpio_in[32] = 1'b0;
   endtask

   // Done when nothing is held in capture and the bus is free
   task automatic wait_idle();
      while (i_dut.instr_pending || gpio_out[33]) step();
   endtask

   task automatic run_instr(input word_t w);
      strobe_word(w);
      model_exec(w);
      wait_idle();
   endtask

   task automatic compare_mem();
      for (int k = 0; k < 64; k++) begin
         check_val($sformatf("%s mem[%0d]", cur_test, k), mem_m[k[5:0]], i_mem.mem[k[5:0]]);
      end
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      $display("%-14s %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "failed",
               test_errors);
   endtask

   task automatic test_reset_idle();
      start_test("reset_idle");
      check_val("reset_idle cyc", 32'd0, 32'(cyc));
      check_val("reset_idle stb", 32'd0, 32'(stb));
      check_val("reset_idle we", 32'd0, 32'(we));
      check_val("reset_idle status pins", 32'd0, 32'(gpio_out[33:32]));
      // Unused pins and analyser outputs stay low
      check_val("reset_idle gpio_out low", 32'd0, gpio_out[31:0]);
      check_val("reset_idle la_data_out", 32'd0, 32'(|la_data_out));
      check_val("reset_idle oeb low", 32'hFFFF_FFFF, gpio_oeb[31:0]);
      check_val("reset_idle oeb status", 32'd0, 32'(gpio_oeb[33:32]));
      end_test();
   endtask

   task automatic test_alu_chain();
      start_test("alu_chain");
      run_instr(enc(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h1234));
      // -5 as immediate
      run_instr(enc(OP_ADDI, 3'd2, 3'd0, 3'd0, 16'hFFFB));
      run_instr(enc(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0));
      run_instr(enc(OP_SUB, 3'd4, 3'd2, 3'd1, 16'h0));
      run_instr(enc(OP_AND, 3'd5, 3'd3, 3'd4, 16'h0));
      run_instr(enc(OP_OR, 3'd6, 3'd3, 3'd4, 16'h0));
      run_instr(enc(OP_XOR, 3'd7, 3'd5, 3'd6, 16'h0));
      // Write to r0 must be lost
      run_instr(enc(OP_ADDI, 3'd0, 3'd1, 3'd0, 16'h0007));
      for (int k = 0; k < 8; k++) begin
         run_instr(enc(OP_SW, 3'd0, 3'd0, 3'(k), 16'(32'h80 + 4 * k)));
         check_val("alu_chain sel", 32'hF, 32'(last_sel));
      end
      compare_mem();
      end_test();
   endtask

   task automatic test_load_store();
      start_test("load_store");
      run_instr(enc(OP_LW, 3'd1, 3'd0, 3'd0, 16'h0020));
      run_instr(enc(OP_SW, 3'd0, 3'd0, 3'd1, 16'h00C0));
      run_instr(enc(OP_ADDI, 3'd3, 3'd0, 3'd0, 16'h0024));
      run_instr(enc(OP_LW, 3'd2, 3'd3, 3'd0, 16'h0004));
      run_instr(enc(OP_SW, 3'd0, 3'd0, 3'd2, 16'h00C4));
      for (int k = 0; k < 4; k++) begin
         run_instr(enc(OP_ADDI, 3'd4, 3'd0, 3'd0, 16'(32'hA0 + 17 * k)));
         run_instr(enc(OP_SB, 3'd0, 3'd0, 3'd4, 16'(32'hD0 + k)));
         check_val($sformatf("load_store byte %0d", k), mem_m[52], i_mem.mem[52]);
      end
      compare_mem();
      end_test();
   endtask

   task automatic test_back_pressure();
      start_test("back_pressure");
      rand_dly = 1'b1;
      for (int k = 0; k < 8; k++) begin
         run_instr(enc(OP_ADDI, 3'd5, 3'd0, 3'd0, 16'(32'h0F00 + 32'h111 * k)));
         run_instr(enc(OP_SW, 3'd0, 3'd0, 3'd5, 16'(32'hE0 + 4 * k)));
         run_instr(enc(OP_LW, 3'd6, 3'd0, 3'd0, 16'(32'hE0 + 4 * ((k + 3) % 8))));
         run_instr(enc(OP_SW, 3'd0, 3'd0, 3'd6, 16'(32'hA0 + 4 * k)));
      end
      rand_dly = 1'b0;
      compare_mem();
      end_test();
   endtask

   task automatic test_enable();
      int n;
      start_test("enable");
      n    = bus_cycles;
      en_i = 1'b0;
      strobe_word(enc(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0777));
      strobe_word(enc(OP_SW, 3'd0, 3'd0, 3'd1, 16'h0040));
      // Capture, take and bus start would all fall inside this window
      repeat (4) step();
      check_val("enable bus cycles", 32'(n), 32'(bus_cycles));
      check_val("enable pending", 32'd0, 32'(i_dut.instr_pending));
      check_val("enable busy", 32'd0, 32'(gpio_out[33]));
      en_i = 1'b1;
      run_instr(enc(OP_SW, 3'd0, 3'd0, 3'd1, 16'h0044));
      compare_mem();
      end_test();
   endtask

   task automatic test_overrun();
      start_test("overrun");
      fixed_wait = 4'd6;
      run_instr(enc(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0055));
      run_instr(enc(OP_ADDI, 3'd2, 3'd0, 3'd0, 16'h0066));
      strobe_word(enc(OP_SW, 3'd0, 3'd0, 3'd1, 16'h0050));
      model_exec(enc(OP_SW, 3'd0, 3'd0, 3'd1, 16'h0050));
      while (!gpio_out[33]) step();
      // First one waits in capture, second is dropped
      strobe_word(enc(OP_SW, 3'd0, 3'd0, 3'd2, 16'h0054));
      model_exec(enc(OP_SW, 3'd0, 3'd0, 3'd2, 16'h0054));
      strobe_word(enc(OP_SW, 3'd0, 3'd0, 3'd2, 16'h0058));
      wait_idle();
      check_val("overrun flag set", 32'd1, 32'(gpio_out[32]));
      compare_mem();
      run_instr(enc(OP_ADDI, 3'd3, 3'd0, 3'd0, 16'h0001));
      check_val("overrun flag sticky", 32'd1, 32'(gpio_out[32]));
      fixed_wait = 4'd0;
      apply_reset();
      check_val("overrun flag after reset", 32'd0, 32'(gpio_out[32]));
      end_test();
   endtask

   initial begin
      rst_i      = 1'b1;
      en_i       = 1'b1;
      la_data_in = '0;
      la_oenb    = '0;
      gpio_in    = '0;
      rand_dly   = 1'b0;
      fixed_wait = 4'd0;
      // Same fill rule as the memory model
      for (int k = 0; k < 64; k++) begin
         if (k < 8) regs_m[k[2:0]] = '0;
         mem_m[k[5:0]] = 32'h5A00_0000 ^ (k * 32'h0001_0307);
      end
      apply_reset();
      test_reset_idle();
      test_alu_chain();
      test_load_store();
      test_back_pressure();
      test_enable();
      test_overrun();
      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* wishbone_manager.sv */
// ##############################
// Output side: Wishbone classic manager, one access at a time
// Read/write pulse starts a cycle, busy stays high until ACK
// ##############################

`include "team_01_defines.svh"

module wishbone_manager import team_01_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   // Bus side inputs
   input  word_t dat_i,
   input  logic  ack_i,
   // Requests from the core
   input  word_t cpu_dat_i,
   input  addr_t adr_i,
   input  sel_t  sel_i,
   input  logic  write_i,
   input  logic  read_i,
   // Bus side outputs
   output addr_t adr_o,
   output word_t dat_o,
   output sel_t  sel_o,
   output logic  we_o,
   output logic  stb_o,
   output logic  cyc_o,
   // Back to the core
   output word_t cpu_dat_o,
   output logic  busy_o
);

   wbm_state_e state_q;

   // Busy for the whole bus cycle
   assign busy_o = (state_q == WAIT_ACK);

   // Control state
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= IDLE;
         cyc_o   <= 1'b0;
         stb_o   <= 1'b0;
         we_o    <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (read_i || write_i) begin
                  state_q <= WAIT_ACK;
                  cyc_o   <= 1'b1;
                  stb_o   <= 1'b1;
                  we_o    <= write_i;
               end
            end
            WAIT_ACK: begin
               // Drop the cycle the edge after ACK
               if (ack_i) begin
                  state_q <= IDLE;
                  cyc_o   <= 1'b0;
                  stb_o   <= 1'b0;
                  we_o    <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Address, data and lanes held steady through the cycle
   always_ff @(posedge clk) begin
      if ((state_q == IDLE) && (read_i || write_i)) begin
         adr_o <= adr_i;
         dat_o <= cpu_dat_i;
         sel_o <= sel_i;
      end
   end

   // Read data kept for the core after the cycle ends
   always_ff @(posedge clk) begin
      if ((state_q == WAIT_ACK) && ack_i && !we_o) begin
         cpu_dat_o <= dat_i;
      end
   end

   // Open cycle stays up with steady outputs until ACK
   a_hold_until_ack: assert property (
      @(posedge clk) disable iff (rst_i)
      (cyc_o && !ack_i) |=> (cyc_o && stb_o && $stable(adr_o) && $stable(dat_o)
                             && $stable(sel_o) && $stable(we_o))
   );

   // Core must hold off while a cycle is open
   a_no_req_when_busy: assert property (
      @(posedge clk) disable iff (rst_i)
      (read_i || write_i) |-> !busy_o
   );

endmodule
